// File: cache_be_pkg.sv
package cache_be_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int ADDR_W = 32;   // byte address, front and back end.
   localparam int DATA_W = 32;   // one memory word.
   localparam int NBYTES = DATA_W / 8;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] word_t;
   typedef logic [NBYTES-1:0] strb_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // bundles
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // one pending write-through word.
   typedef struct packed {
      addr_t addr;   // word aligned.
      word_t data;
      strb_t strb;
   } wr_entry_t;

   // request toward memory, zero wstrb is a read.
   typedef struct packed {
      logic  avalid;
      addr_t addr;
      word_t wdata;
      strb_t wstrb;
   } be_req_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // fsm states
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic {
      WR_IDLE,
      WR_SEND
   } wr_state_t;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_REQ,
      RD_WAIT,
      RD_DONE
   } rd_state_t;

endpackage

// File: cache_be_write_buffer.sv
`timescale 1ns/1ps

module cache_be_write_buffer import cache_be_pkg::*; #(
   parameter int BUF_DEPTH = 4
) (
   input  logic      clk_i,
   input  logic      reset_i,

   input  logic      push_i,
   input  wr_entry_t push_entry_i,
   output logic      full_o,
   output logic      empty_o,

   input  logic      pop_i,
   output wr_entry_t head_o,
   output logic      head_valid_o
);

   localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int CNT_W = $clog2(BUF_DEPTH + 1);

   wr_entry_t        mem_q [BUF_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;

   assign empty_o      = (count_q == '0);
   assign full_o       = (count_q == CNT_W'(BUF_DEPTH));
   assign head_valid_o = ~empty_o;
   assign head_o       = mem_q[rd_ptr_q];   // fall-through head.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // storage
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem_q[wr_ptr_q] <= push_entry_i;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // pointers and occupancy
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps, depth is a power of two.
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // top level and write channel must qualify their strobes.
   a_no_overflow: assert property (
      @(posedge clk_i) disable iff (reset_i)
      !(push_i && full_o) && !(pop_i && empty_o)
   ) else $error("write buffer push on full or pop on empty");

endmodule

// File: cache_be_write_channel.sv
`timescale 1ns/1ps

module cache_be_write_channel import cache_be_pkg::*; (
   input  logic      clk_i,
   input  logic      reset_i,

   // buffer head
   input  wr_entry_t head_i,
   input  logic      head_valid_i,
   output logic      pop_o,

   // back-end request
   output be_req_t   be_req_o,
   input  logic      be_ack_i,
   output logic      busy_o
);

   wr_state_t state_q;
   wr_state_t state_d;
   wr_entry_t req_q;

   // load on idle, or right behind an accepted word.
   assign pop_o  = head_valid_i && ((state_q == WR_IDLE) || be_ack_i);
   assign busy_o = (state_q == WR_SEND);

   assign be_req_o.avalid = (state_q == WR_SEND);
   assign be_req_o.addr   = req_q.addr;
   assign be_req_o.wdata  = req_q.data;
   assign be_req_o.wstrb  = req_q.strb;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // fsm
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      state_d = state_q;
      case (state_q)
         WR_IDLE: begin
            if (head_valid_i) begin
               state_d = WR_SEND;
            end
         end
         WR_SEND: begin
            if (be_ack_i && !head_valid_i) begin
               state_d = WR_IDLE;   // nothing queued behind it.
            end
         end
         default: state_d = WR_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= WR_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         req_q <= head_i;
      end
   end

   // a front-end entry with no byte enabled would look like a read.
   a_strb_nonzero: assert property (
      @(posedge clk_i) disable iff (reset_i)
      be_req_o.avalid |-> (be_req_o.wstrb != '0)
   ) else $error("write request with zero strobe");

endmodule

// File: cache_be_read_channel.sv
`timescale 1ns/1ps

module cache_be_read_channel import cache_be_pkg::*; #(
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                     clk_i,
   input  logic                     reset_i,

   // replacement port
   input  logic                     replace_valid_i,
   input  addr_t                    replace_addr_i,
   input  logic                     start_ok_i,
   output logic                     replace_o,
   output logic                     read_valid_o,
   output logic [WORD_OFFSET_W-1:0] read_addr_o,
   output word_t                    read_rdata_o,

   // back-end request
   output be_req_t                  be_req_o,
   input  logic                     be_ack_i,
   input  logic                     be_rvalid_i,
   input  word_t                    be_rdata_i
);

   localparam int BOFF_W     = $clog2(NBYTES);
   localparam int LINE_OFF_W = WORD_OFFSET_W + BOFF_W;

   rd_state_t                      state_q;
   rd_state_t                      state_d;
   logic [ADDR_W-LINE_OFF_W-1:0]   line_q;
   logic [WORD_OFFSET_W-1:0]       idx_q;
   logic                           start;
   logic                           last_word;

   assign start     = (state_q == RD_IDLE) && replace_valid_i && start_ok_i;
   assign last_word = &idx_q;

   assign replace_o    = (state_q == RD_REQ) || (state_q == RD_WAIT);
   assign read_valid_o = (state_q == RD_WAIT) && be_rvalid_i;
   assign read_addr_o  = idx_q;
   assign read_rdata_o = be_rdata_i;

   assign be_req_o.avalid = (state_q == RD_REQ);
   assign be_req_o.addr   = {line_q, idx_q, {BOFF_W{1'b0}}};   // base plus idx*4.
   assign be_req_o.wdata  = '0;
   assign be_req_o.wstrb  = '0;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // fsm
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      state_d = state_q;
      case (state_q)
         RD_IDLE: begin
            if (start) begin
               state_d = RD_REQ;
            end
         end
         RD_REQ: begin
            if (be_ack_i) begin
               state_d = RD_WAIT;
            end
         end
         RD_WAIT: begin
            if (be_rvalid_i) begin
               state_d = last_word ? RD_DONE : RD_REQ;
            end
         end
         // one cycle for the cache to drop its request.
         RD_DONE: state_d = RD_IDLE;
         default: state_d = RD_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= RD_IDLE;
         idx_q   <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == RD_IDLE) begin
            idx_q <= '0;
         end else if (read_valid_o) begin
            idx_q <= idx_q + 1'b1;   // wraps after the last word.
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start) begin
         line_q <= replace_addr_i[ADDR_W-1:LINE_OFF_W];
      end
   end

   a_rvalid_in_wait: assert property (
      @(posedge clk_i) disable iff (reset_i)
      be_rvalid_i |-> (state_q == RD_WAIT)
   ) else $error("read data outside of wait state");

endmodule

// File: cache_be_back_end.sv
`timescale 1ns/1ps

module cache_be_back_end import cache_be_pkg::*; #(
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                     clk_i,
   input  logic                     reset_i,

   // write buffer
   input  wr_entry_t                head_i,
   input  logic                     head_valid_i,
   output logic                     pop_o,
   input  logic                     buf_empty_i,

   // cache-line replacement
   input  logic                     replace_valid_i,
   input  addr_t                    replace_addr_i,
   output logic                     replace_o,
   output logic                     read_valid_o,
   output logic [WORD_OFFSET_W-1:0] read_addr_o,
   output word_t                    read_rdata_o,

   // memory
   output be_req_t                  mem_req_o,
   input  logic                     mem_ready_i,
   input  logic                     mem_rvalid_i,
   input  word_t                    mem_rdata_i
);

   be_req_t rd_req;
   be_req_t wr_req;
   logic    wr_busy;
   logic    wr_head_valid;
   logic    start_ok;
   logic    sel_rd;
   logic    accept;
   logic    rd_ack;
   logic    wr_ack;
   logic    rd_owner_q;
   logic    rd_rvalid;

   // fill waits for every buffered write to be accepted.
   assign start_ok      = buf_empty_i & ~wr_busy;
   assign wr_head_valid = head_valid_i & ~replace_o;   // writes held during a fill.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // request mux and acknowledge
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign sel_rd    = rd_req.avalid;
   assign mem_req_o = sel_rd ? rd_req : wr_req;
   assign accept    = mem_req_o.avalid & mem_ready_i;
   assign rd_ack    = accept & sel_rd;
   assign wr_ack    = accept & ~sel_rd;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rd_owner_q <= 1'b0;
      end else if (accept) begin
         rd_owner_q <= sel_rd;   // owner of the last accepted request.
      end
   end

   assign rd_rvalid = mem_rvalid_i & rd_owner_q;

   cache_be_read_channel #(
      .WORD_OFFSET_W(WORD_OFFSET_W)
   ) read_fsm (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .replace_valid_i(replace_valid_i),
      .replace_addr_i (replace_addr_i),
      .start_ok_i     (start_ok),
      .replace_o      (replace_o),
      .read_valid_o   (read_valid_o),
      .read_addr_o    (read_addr_o),
      .read_rdata_o   (read_rdata_o),
      .be_req_o       (rd_req),
      .be_ack_i       (rd_ack),
      .be_rvalid_i    (rd_rvalid),
      .be_rdata_i     (mem_rdata_i)
   );

   cache_be_write_channel write_fsm (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .head_i      (head_i),
      .head_valid_i(wr_head_valid),
      .pop_o       (pop_o),
      .be_req_o    (wr_req),
      .be_ack_i    (wr_ack),
      .busy_o      (wr_busy)
   );

endmodule

// File: cache_be_top.sv
`timescale 1ns/1ps

module cache_be_top import cache_be_pkg::*; #(
   parameter int WORD_OFFSET_W = 2,
   parameter int BUF_DEPTH     = 4
) (
   input  logic                     clk_i,
   input  logic                     reset_i,

   // front-end write-through port
   input  logic                     write_valid_i,
   input  wr_entry_t                write_entry_i,
   output logic                     write_ready_o,

   // cache-line replacement
   input  logic                     replace_valid_i,
   input  addr_t                    replace_addr_i,
   output logic                     replace_o,
   output logic                     read_valid_o,
   output logic [WORD_OFFSET_W-1:0] read_addr_o,
   output word_t                    read_rdata_o,

   // memory
   output be_req_t                  mem_req_o,
   input  logic                     mem_ready_i,
   input  logic                     mem_rvalid_i,
   input  word_t                    mem_rdata_i
);

   wr_entry_t buf_head;
   logic      buf_valid;
   logic      buf_pop;
   logic      buf_push;
   logic      buf_full;
   logic      buf_empty;

   assign write_ready_o = ~buf_full;
   assign buf_push      = write_valid_i & ~buf_full;

   cache_be_write_buffer #(
      .BUF_DEPTH(BUF_DEPTH)
   ) write_buf (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .push_i      (buf_push),
      .push_entry_i(write_entry_i),
      .full_o      (buf_full),
      .empty_o     (buf_empty),
      .pop_i       (buf_pop),
      .head_o      (buf_head),
      .head_valid_o(buf_valid)
   );

   cache_be_back_end #(
      .WORD_OFFSET_W(WORD_OFFSET_W)
   ) back_end (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .head_i         (buf_head),
      .head_valid_i   (buf_valid),
      .pop_o          (buf_pop),
      .buf_empty_i    (buf_empty),
      .replace_valid_i(replace_valid_i),
      .replace_addr_i (replace_addr_i),
      .replace_o      (replace_o),
      .read_valid_o   (read_valid_o),
      .read_addr_o    (read_addr_o),
      .read_rdata_o   (read_rdata_o),
      .mem_req_o      (mem_req_o),
      .mem_ready_i    (mem_ready_i),
      .mem_rvalid_i   (mem_rvalid_i),
      .mem_rdata_i    (mem_rdata_i)
   );

endmodule

// File: cache_be_tb.sv
`timescale 1ns/1ps

module cache_be_tb import cache_be_pkg::*; ();

   localparam int WORD_OFFSET_W = 2;
   localparam int BUF_DEPTH     = 4;
   localparam int LINE_WORDS    = 1 << WORD_OFFSET_W;
   localparam int TIMEOUT       = 500;

   logic                     clk_i;
   logic                     reset_i;
   logic                     write_valid_i;
   wr_entry_t                write_entry_i;
   logic                     write_ready_o;
   logic                     replace_valid_i;
   addr_t                    replace_addr_i;
   logic                     replace_o;
   logic                     read_valid_o;
   logic [WORD_OFFSET_W-1:0] read_addr_o;
   word_t                    read_rdata_o;
   be_req_t                  mem_req_o;
   logic                     mem_ready_i;
   logic                     mem_rvalid_i;
   word_t                    mem_rdata_i;

   word_t       mem [64];      // memory model.
   word_t       shadow [64];   // expected memory contents.
   wr_entry_t   exp_q [$];
   logic [31:0] mem_rng;
   logic [31:0] stim_rng;
   string       test_name;
   logic        hold_ready_low;
   logic [3:0]  fill_line;
   logic        acc_rd_q;
   logic [5:0]  acc_idx_q;
   logic        rd_pend;
   logic [5:0]  rd_idx;
   int          rd_cnt;
   int          reset_cycles;
   logic        post_reset_q;
   logic        replace_prev_q;
   logic        beat_prev_q;
   int          beat_cnt;

   cache_be_top #(
      .WORD_OFFSET_W(WORD_OFFSET_W),
      .BUF_DEPTH    (BUF_DEPTH)
   ) cache_be_top_inst (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic compare_fail(input string what, input logic [31:0] exp, input logic [31:0] act);
      $display("mismatch in %s (%s): expected %h actual %h", test_name, what, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "check failed");
   endtask

   task automatic fail_with(input string what);
      $display("%s: %s", test_name, what);
      $display("STATUS: FAIL");
      $fatal(1, "check failed");
   endtask

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // memory model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(posedge clk_i) begin
      wr_entry_t e;
      acc_rd_q <= 1'b0;
      if (!reset_i && mem_req_o.avalid && mem_ready_i) begin
         if (mem_req_o.wstrb != '0) begin
            for (int b = 0; b < NBYTES; b++) begin
               if (mem_req_o.wstrb[b]) begin
                  mem[mem_req_o.addr[7:2]][8*b +: 8] = mem_req_o.wdata[8*b +: 8];
               end
            end
            if (exp_q.size() == 0) begin
               fail_with("memory write with no entry pending");
            end
            e = exp_q.pop_front();
            assert (mem_req_o.addr == e.addr) else compare_fail("waddr", e.addr, mem_req_o.addr);
            assert (mem_req_o.wdata == e.data)
               else compare_fail("wdata", e.data, mem_req_o.wdata);
            assert (mem_req_o.wstrb == e.strb)
               else compare_fail("wstrb", 32'(e.strb), 32'(mem_req_o.wstrb));
         end else begin
            assert (exp_q.size() == 0) else fail_with("line read issued before writes drained");
            acc_rd_q  <= 1'b1;
            acc_idx_q <= mem_req_o.addr[7:2];
         end
      end
   end

   always @(negedge clk_i) begin
      mem_rng     = xorshift32(mem_rng);
      mem_ready_i = !hold_ready_low && (mem_rng[1:0] != 2'b00);   // about 3 in 4.
      mem_rvalid_i = 1'b0;
      if (acc_rd_q) begin
         rd_pend = 1'b1;
         rd_idx  = acc_idx_q;
         rd_cnt  = 1 + int'(mem_rng[9:8]);
      end
      if (rd_pend) begin
         rd_cnt = rd_cnt - 1;
         if (rd_cnt == 0) begin
            mem_rvalid_i = 1'b1;
            mem_rdata_i  = mem[rd_idx];
            rd_pend      = 1'b0;
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // output checks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(posedge clk_i) begin
      post_reset_q <= reset_i;
      if ((reset_i && reset_cycles > 0) || post_reset_q) begin
         assert (!replace_o) else compare_fail("replace_o in reset", 0, 32'(replace_o));
         assert (!read_valid_o)
            else compare_fail("read_valid_o in reset", 0, 32'(read_valid_o));
         assert (!mem_req_o.avalid)
            else compare_fail("avalid in reset", 0, 32'(mem_req_o.avalid));
      end
      if (!reset_i) begin
         if (read_valid_o) begin
            assert (beat_cnt < LINE_WORDS) else fail_with("too many fill beats");
            assert (read_addr_o == beat_cnt[WORD_OFFSET_W-1:0])
               else compare_fail("read_addr_o", beat_cnt, 32'(read_addr_o));
            assert (read_rdata_o == shadow[{fill_line, beat_cnt[WORD_OFFSET_W-1:0]}])
               else compare_fail("read_rdata_o",
                                 shadow[{fill_line, beat_cnt[WORD_OFFSET_W-1:0]}],
                                 read_rdata_o);
            beat_cnt = beat_cnt + 1;
         end
         if (replace_prev_q && !replace_o) begin
            assert (beat_cnt == LINE_WORDS)
               else compare_fail("beat count", LINE_WORDS, beat_cnt);
            assert (beat_prev_q) else fail_with("replace_o fell without a last beat before it");
            beat_cnt = 0;
         end
      end
      replace_prev_q <= replace_o;
      beat_prev_q    <= read_valid_o;
      reset_cycles = reset_i ? reset_cycles + 1 : 0;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stimulus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic push_write(input logic [5:0] idx, input word_t data, input strb_t strb);
      int t;
      t = 0;
      while (!write_ready_o) begin
         t++;
         if (t > TIMEOUT) fail_with("timeout waiting for write_ready_o");
         @(negedge clk_i);
      end
      write_valid_i = 1'b1;
      write_entry_i = '{addr: {24'h0, idx, 2'b00}, data: data, strb: strb};
      exp_q.push_back(write_entry_i);
      for (int b = 0; b < NBYTES; b++) begin
         if (strb[b]) shadow[idx][8*b +: 8] = data[8*b +: 8];
      end
      @(negedge clk_i);
      write_valid_i = 1'b0;
   endtask

   task automatic wait_drained();
      int t;
      t = 0;
      while (exp_q.size() != 0) begin
         t++;
         if (t > TIMEOUT) fail_with("timeout waiting for writes to reach memory");
         @(negedge clk_i);
      end
   endtask

   task automatic fill(input logic [3:0] line);
      int t;
      fill_line       = line;
      replace_valid_i = 1'b1;
      replace_addr_i  = {24'h0, line, 4'h0};
      t = 0;
      while (!replace_o) begin
         t++;
         if (t > TIMEOUT) fail_with("timeout waiting for fill to start");
         @(negedge clk_i);
      end
      t = 0;
      while (replace_o) begin
         t++;
         if (t > TIMEOUT) fail_with("timeout waiting for fill to end");
         @(negedge clk_i);
      end
      replace_valid_i = 1'b0;
      @(negedge clk_i);
   endtask

   initial begin
      int n;
      mem_rng        = 32'h6199;
      stim_rng       = xorshift32(32'h6199 ^ 32'hffff);
      hold_ready_low = 1'b0;
      rd_pend        = 1'b0;
      rd_cnt         = 0;
      beat_cnt       = 0;
      reset_cycles   = 0;
      fill_line      = '0;
      test_name      = "reset";
      for (int i = 0; i < 64; i++) begin
         mem[i]    = 32'h5a000000 ^ (i * 32'h01030507);   // distinct per word.
         shadow[i] = mem[i];
      end
      reset_i         = 1'b1;
      write_valid_i   = 1'b0;
      write_entry_i   = '0;
      replace_valid_i = 1'b0;
      replace_addr_i  = '0;
      mem_ready_i     = 1'b0;
      mem_rvalid_i    = 1'b0;
      mem_rdata_i     = '0;
      repeat (4) @(negedge clk_i);
      reset_i = 1'b0;
      repeat (2) @(negedge clk_i);

      test_name = "write order";
      for (int i = 0; i < 16; i++) begin
         stim_rng = xorshift32(stim_rng);
         push_write(stim_rng[5:0], xorshift32(stim_rng), 4'hf);
      end
      wait_drained();
      fill(4'd0);
      fill(4'd9);

      test_name = "byte strobes";
      push_write(6'd8, 32'h11223344, 4'b0001);
      push_write(6'd9, 32'haabbccdd, 4'b0110);
      push_write(6'd11, 32'hdeadbeef, 4'b1000);
      push_write(6'd8, 32'h99887766, 4'b0100);
      wait_drained();
      fill(4'd2);

      test_name = "coherence";
      push_write(6'd20, 32'hcafef00d, 4'hf);
      push_write(6'd21, 32'h0badc0de, 4'b0011);
      push_write(6'd23, 32'h12345678, 4'b1100);
      fill(4'd5);

      test_name = "back-pressure";
      @(negedge clk_i);
      hold_ready_low = 1'b1;
      wait_drained();
      @(negedge clk_i);
      n = 0;
      while (write_ready_o) begin
         stim_rng = xorshift32(stim_rng);
         push_write(6'd32 + n[5:0], stim_rng, 4'hf);
         n++;
         if (n > BUF_DEPTH + 4) fail_with("write_ready_o never fell with memory stalled");
      end
      assert (n == BUF_DEPTH + 1) else compare_fail("entries before full", BUF_DEPTH + 1, n);
      hold_ready_low = 1'b0;
      wait_drained();
      fill(4'd8);
      fill(4'd9);

      repeat (4) @(negedge clk_i);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: cache_be.f
cache_be_pkg.sv
cache_be_write_buffer.sv
cache_be_write_channel.sv
cache_be_read_channel.sv
cache_be_back_end.sv
cache_be_top.sv
cache_be_tb.sv

// File: run.sh
#!/bin/sh
# build and run the cache back-end testbench with Verilator
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --top-module cache_be_tb -f cache_be.f \
   -o cache_be_sim && ./obj_dir/cache_be_sim; } > sim.log 2>&1
grep -q "STATUS: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "simulation did not pass, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
